//--- source/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define EXEC_XLEN      64
`define EXEC_QDEPTH    4
`define EXEC_DIV_STEPS `EXEC_XLEN

`endif

//--- source/execPkg.sv
`include "exec_cfg.svh"

package execPkg;

    typedef logic [`EXEC_XLEN-1:0] xword_t;
    typedef logic [31:0] inst_t;
    typedef logic [7:0] wmask_t;
    typedef logic [3:0] rdnum_t; // load bytes: 0, 1, 2, 4 or 8

    typedef enum logic [4:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU,
        ALU_RETB // pass b through, lui
    } aluOp_t;

    typedef enum logic {SELA_PC, SELA_RS1} selA_t;
    typedef enum logic {SELB_IMM, SELB_RS2} selB_t;

    typedef enum logic [1:0] {WB_ALU, WB_LINK, WB_WORD, WB_NONE} wbSel_t;

    typedef enum logic [2:0] {
        BR_NEVER, BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } brCond_t;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} divState_t;

endpackage

//--- source/instDecoder.sv
module instDecoder (
    input  logic clk,
    input  logic rst,
    input  logic instValid,
    input  execPkg::inst_t inst,
    input  execPkg::xword_t imm, rs1, rs2, pc,
    output logic decValid,
    output execPkg::aluOp_t decAluOp,
    output execPkg::selA_t decSelA,
    output execPkg::selB_t decSelB,
    output execPkg::wbSel_t decWbSel,
    output execPkg::brCond_t decBrCond,
    output logic decJumpReg, decRdWrite, decMemRead,
    output execPkg::wmask_t decMemWriteMask,
    output execPkg::rdnum_t decReadNum,
    output logic decLoadSext, decShift32, decIllegal,
    output execPkg::xword_t decImm, decRs1, decRs2, decPc
);
    import execPkg::*;

    logic [6:0] opCode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    aluOp_t aluOp;
    selA_t selA;
    selB_t selB;
    wbSel_t wbSel;
    brCond_t brCond;
    wmask_t memWriteMask;
    rdnum_t readNum;
    logic jumpReg, rdWrite, memRead, loadSext, shift32, bad;

    assign opCode = inst[6:0];
    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];

    always_comb begin
        aluOp = ALU_NONE;
        selA = SELA_RS1;
        selB = SELB_IMM;
        wbSel = WB_NONE;
        brCond = BR_NEVER;
        jumpReg = 1'b0;
        rdWrite = 1'b0;
        memRead = 1'b0;
        memWriteMask = '0;
        readNum = '0;
        loadSext = 1'b0;
        shift32 = 1'b0;
        bad = 1'b0;
        case (opCode)
            7'b0110011: begin // R type
                selB = SELB_RS2;
                wbSel = WB_ALU;
                rdWrite = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: aluOp = ALU_ADD;
                    10'b0100000_000: aluOp = ALU_SUB;
                    10'b0000000_001: aluOp = ALU_SLL;
                    10'b0000000_010: aluOp = ALU_SLT;
                    10'b0000000_011: aluOp = ALU_SLTU;
                    10'b0000000_100: aluOp = ALU_XOR;
                    10'b0000000_101: aluOp = ALU_SRL;
                    10'b0100000_101: aluOp = ALU_SRA;
                    10'b0000000_110: aluOp = ALU_OR;
                    10'b0000000_111: aluOp = ALU_AND;
                    10'b0000001_000: aluOp = ALU_MUL;
                    10'b0000001_100: aluOp = ALU_DIV;
                    10'b0000001_101: aluOp = ALU_DIVU;
                    10'b0000001_110: aluOp = ALU_REM;
                    10'b0000001_111: aluOp = ALU_REMU;
                    default: bad = 1'b1; // mulh family not supported
                endcase
            end
            7'b0010011: begin // I type
                wbSel = WB_ALU;
                rdWrite = 1'b1;
                case (funct3)
                    3'b000: aluOp = ALU_ADD;
                    3'b010: aluOp = ALU_SLT;
                    3'b011: aluOp = ALU_SLTU;
                    3'b100: aluOp = ALU_XOR;
                    3'b110: aluOp = ALU_OR;
                    3'b111: aluOp = ALU_AND;
                    3'b001: begin
                        if (funct7[6:1] == 6'h00) aluOp = ALU_SLL;
                        else bad = 1'b1;
                    end
                    default: begin // 3'b101, shamt takes funct7[0]
                        case (funct7[6:1])
                            6'h00: aluOp = ALU_SRL;
                            6'h10: aluOp = ALU_SRA;
                            default: bad = 1'b1;
                        endcase
                    end
                endcase
            end
            7'b0111011: begin // word register forms
                selB = SELB_RS2;
                wbSel = WB_WORD;
                rdWrite = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: aluOp = ALU_ADD;
                    10'b0100000_000: aluOp = ALU_SUB;
                    10'b0000000_001: aluOp = ALU_SLL;
                    10'b0000000_101: begin
                        aluOp = ALU_SRL;
                        shift32 = 1'b1;
                    end
                    10'b0100000_101: begin
                        aluOp = ALU_SRA;
                        shift32 = 1'b1;
                    end
                    10'b0000001_000: aluOp = ALU_MUL;
                    10'b0000001_100: aluOp = ALU_DIV;
                    10'b0000001_101: aluOp = ALU_DIVU;
                    10'b0000001_110: aluOp = ALU_REM;
                    10'b0000001_111: aluOp = ALU_REMU;
                    default: bad = 1'b1;
                endcase
            end
            7'b0011011: begin // word immediate forms
                wbSel = WB_WORD;
                rdWrite = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_001: aluOp = ALU_SLL;
                    10'b0000000_101: begin
                        aluOp = ALU_SRL;
                        shift32 = 1'b1;
                    end
                    10'b0100000_101: begin
                        aluOp = ALU_SRA;
                        shift32 = 1'b1;
                    end
                    default: begin
                        if (funct3 == 3'b000) aluOp = ALU_ADD; // addiw, any imm
                        else bad = 1'b1;
                    end
                endcase
            end
            7'b0000011: begin // loads, address is rs1 + imm
                aluOp = ALU_ADD;
                wbSel = WB_ALU;
                rdWrite = 1'b1;
                memRead = 1'b1;
                readNum = rdnum_t'(4'b0001 << funct3[1:0]);
                loadSext = ~funct3[2];
                if (funct3 == 3'b111) bad = 1'b1;
            end
            7'b0100011: begin // stores
                aluOp = ALU_ADD;
                wbSel = WB_ALU;
                case (funct3)
                    3'b000: memWriteMask = 8'b0000_0001;
                    3'b001: memWriteMask = 8'b0000_0011;
                    3'b010: memWriteMask = 8'b0000_1111;
                    3'b011: memWriteMask = 8'b1111_1111;
                    default: bad = 1'b1;
                endcase
            end
            7'b0110111: begin // lui
                aluOp = ALU_RETB;
                wbSel = WB_ALU;
                rdWrite = 1'b1;
            end
            7'b0010111: begin // auipc
                aluOp = ALU_ADD;
                selA = SELA_PC;
                wbSel = WB_ALU;
                rdWrite = 1'b1;
            end
            7'b1101111: begin // jal
                wbSel = WB_LINK;
                brCond = BR_ALWAYS;
                rdWrite = 1'b1;
            end
            7'b1100111: begin // jalr
                wbSel = WB_LINK;
                brCond = BR_ALWAYS;
                jumpReg = 1'b1;
                rdWrite = 1'b1;
                if (funct3 != 3'b000) bad = 1'b1;
            end
            7'b1100011: begin // branches, compared in execute
                case (funct3)
                    3'b000: brCond = BR_EQ;
                    3'b001: brCond = BR_NE;
                    3'b100: brCond = BR_LT;
                    3'b101: brCond = BR_GE;
                    3'b110: brCond = BR_LTU;
                    3'b111: brCond = BR_GEU;
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin // illegal op must not write or touch memory
            aluOp = ALU_NONE;
            wbSel = WB_NONE;
            brCond = BR_NEVER;
            jumpReg = 1'b0;
            rdWrite = 1'b0;
            memRead = 1'b0;
            memWriteMask = '0;
            readNum = '0;
            loadSext = 1'b0;
            shift32 = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= instValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instValid) begin
            decAluOp <= aluOp;
            decSelA <= selA;
            decSelB <= selB;
            decWbSel <= wbSel;
            decBrCond <= brCond;
            decJumpReg <= jumpReg;
            decRdWrite <= rdWrite;
            decMemRead <= memRead;
            decMemWriteMask <= memWriteMask;
            decReadNum <= readNum;
            decLoadSext <= loadSext;
            decShift32 <= shift32;
            decIllegal <= bad;
            decImm <= imm;
            decRs1 <= rs1;
            decRs2 <= rs2;
            decPc <= pc;
        end
    end

endmodule

//--- source/opQueue.sv
`include "exec_cfg.svh"

module opQueue (
    input  logic clk,
    input  logic rst,
    input  logic decValid,
    input  logic pop,
    input  execPkg::aluOp_t decAluOp,
    input  execPkg::selA_t decSelA,
    input  execPkg::selB_t decSelB,
    input  execPkg::wbSel_t decWbSel,
    input  execPkg::brCond_t decBrCond,
    input  logic decJumpReg, decRdWrite, decMemRead,
    input  execPkg::wmask_t decMemWriteMask,
    input  execPkg::rdnum_t decReadNum,
    input  logic decLoadSext, decShift32, decIllegal,
    input  execPkg::xword_t decImm, decRs1, decRs2, decPc,
    output logic headValid,
    output logic queueFull,
    output logic overflowErr,
    output execPkg::aluOp_t headAluOp,
    output execPkg::selA_t headSelA,
    output execPkg::selB_t headSelB,
    output execPkg::wbSel_t headWbSel,
    output execPkg::brCond_t headBrCond,
    output logic headJumpReg, headRdWrite, headMemRead,
    output execPkg::wmask_t headMemWriteMask,
    output execPkg::rdnum_t headReadNum,
    output logic headLoadSext, headShift32, headIllegal,
    output execPkg::xword_t headImm, headRs1, headRs2, headPc
);
    import execPkg::*;

    localparam int PW = $clog2(`EXEC_QDEPTH);
    localparam int CW = $clog2(`EXEC_QDEPTH + 1);

    typedef struct packed {
        aluOp_t aluOp;
        selA_t selA;
        selB_t selB;
        wbSel_t wbSel;
        brCond_t brCond;
        logic jumpReg;
        logic rdWrite;
        logic memRead;
        wmask_t memWriteMask;
        rdnum_t readNum;
        logic loadSext;
        logic shift32;
        logic illegal;
        xword_t imm;
        xword_t rs1;
        xword_t rs2;
        xword_t pc;
    } opRec_t;

    opRec_t mem [`EXEC_QDEPTH];
    opRec_t head;
    logic [PW-1:0] wrPtr, rdPtr;
    logic [CW-1:0] count;
    logic doWrite;

    assign doWrite = decValid && (count != CW'(`EXEC_QDEPTH) || pop);
    assign headValid = count != '0;
    // entry still in decode counts against the depth
    assign queueFull = (32'(count) + 32'(decValid)) >= `EXEC_QDEPTH;

    assign head = mem[rdPtr];
    assign headAluOp = head.aluOp;
    assign headSelA = head.selA;
    assign headSelB = head.selB;
    assign headWbSel = head.wbSel;
    assign headBrCond = head.brCond;
    assign headJumpReg = head.jumpReg;
    assign headRdWrite = head.rdWrite;
    assign headMemRead = head.memRead;
    assign headMemWriteMask = head.memWriteMask;
    assign headReadNum = head.readNum;
    assign headLoadSext = head.loadSext;
    assign headShift32 = head.shift32;
    assign headIllegal = head.illegal;
    assign headImm = head.imm;
    assign headRs1 = head.rs1;
    assign headRs2 = head.rs2;
    assign headPc = head.pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            overflowErr <= 1'b0;
        end else begin
            if (doWrite) wrPtr <= wrPtr + 1'b1; // depth is a power of two
            if (pop) rdPtr <= rdPtr + 1'b1;
            count <= count + CW'(doWrite) - CW'(pop);
            if (decValid && !doWrite) overflowErr <= 1'b1; // sticky
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= {decAluOp, decSelA, decSelB, decWbSel, decBrCond, decJumpReg,
                           decRdWrite, decMemRead, decMemWriteMask, decReadNum, decLoadSext,
                           decShift32, decIllegal, decImm, decRs1, decRs2, decPc};
        end
    end

endmodule

//--- source/serialDivider.sv
`include "exec_cfg.svh"

module serialDivider (
    input  logic clk,
    input  logic rst,
    input  logic divStart,
    input  execPkg::xword_t dividend, divisor,
    input  logic divSigned, divRem, divWord,
    output logic divDone,
    output execPkg::xword_t divResult
);
    import execPkg::*;

    localparam int XL = `EXEC_XLEN;
    localparam int CW = $clog2(`EXEC_DIV_STEPS) + 1;

    divState_t state;
    logic [CW-1:0] stepCnt;
    xword_t numA, numB, savedA, absB, quo, rem, pick;
    logic [XL:0] trial;
    logic negQ, negR, zeroDiv, wantRem, isWord;

    always_comb begin
        numA = dividend;
        numB = divisor;
        if (divWord) begin // narrow to 32 bits first
            numA = {{(XL - 32){divSigned & dividend[31]}}, dividend[31:0]};
            numB = {{(XL - 32){divSigned & divisor[31]}}, divisor[31:0]};
        end
        trial = {rem, quo[XL-1]} - {1'b0, absB};
        if (zeroDiv) begin
            pick = wantRem ? savedA : '1;
        end else if (wantRem) begin
            pick = negR ? -rem : rem;
        end else begin
            pick = negQ ? -quo : quo;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
            stepCnt <= '0;
            divDone <= 1'b0;
        end else begin
            divDone <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    stepCnt <= '0;
                    if (divStart) state <= DIV_RUN;
                end
                DIV_RUN: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == CW'(`EXEC_DIV_STEPS - 1)) state <= DIV_DONE;
                end
                default: begin
                    divDone <= 1'b1;
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && divStart) begin
            savedA <= numA;
            quo <= (divSigned && numA[XL-1]) ? -numA : numA;
            absB <= (divSigned && numB[XL-1]) ? -numB : numB;
            rem <= '0;
            negQ <= divSigned & (numA[XL-1] ^ numB[XL-1]);
            negR <= divSigned & numA[XL-1];
            zeroDiv <= numB == '0;
            wantRem <= divRem;
            isWord <= divWord;
        end else if (state == DIV_RUN) begin
            if (!trial[XL]) begin // no borrow, keep the difference
                rem <= trial[XL-1:0];
                quo <= {quo[XL-2:0], 1'b1};
            end else begin
                rem <= {rem[XL-2:0], quo[XL-1]};
                quo <= {quo[XL-2:0], 1'b0};
            end
        end
        if (state == DIV_DONE) begin
            divResult <= isWord ? {{(XL - 32){pick[31]}}, pick[31:0]} : pick;
        end
    end

endmodule

//--- source/execUnit.sv
module execUnit (
    input  logic clk,
    input  logic rst,
    input  logic headValid,
    input  execPkg::aluOp_t headAluOp,
    input  execPkg::selA_t headSelA,
    input  execPkg::selB_t headSelB,
    input  execPkg::wbSel_t headWbSel,
    input  execPkg::brCond_t headBrCond,
    input  logic headJumpReg, headRdWrite, headMemRead,
    input  execPkg::wmask_t headMemWriteMask,
    input  execPkg::rdnum_t headReadNum,
    input  logic headLoadSext, headShift32, headIllegal,
    input  execPkg::xword_t headImm, headRs1, headRs2, headPc,
    output logic pop,
    output logic resultValid,
    output execPkg::xword_t result,
    output logic rdWrite, memRead,
    output execPkg::wmask_t memWriteMask,
    output execPkg::rdnum_t readNum,
    output logic loadSext, branchTaken,
    output execPkg::xword_t branchTarget,
    output logic illegal
);
    import execPkg::*;

    xword_t opA, opB, aluOut, nextResult;
    xword_t dividend, divisor, divResult;
    logic [5:0] shamt;
    logic isDiv, taken, busy;
    logic divStart, divSigned, divRem, divWord, divDone;

    assign pop = headValid && !busy;
    assign isDiv = headAluOp inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};

    always_comb begin
        opA = (headSelA == SELA_PC) ? headPc : headRs1;
        if (headShift32) begin // srlw zero fills, sraw sign fills
            opA = {{32{headAluOp == ALU_SRA && headRs1[31]}}, headRs1[31:0]};
        end
        opB = (headSelB == SELB_RS2) ? headRs2 : headImm;
        shamt = (headWbSel == WB_WORD) ? {1'b0, opB[4:0]} : opB[5:0];
        case (headAluOp)
            ALU_ADD: aluOut = opA + opB;
            ALU_SUB: aluOut = opA - opB;
            ALU_XOR: aluOut = opA ^ opB;
            ALU_OR: aluOut = opA | opB;
            ALU_AND: aluOut = opA & opB;
            ALU_SLL: aluOut = opA << shamt;
            ALU_SRL: aluOut = opA >> shamt;
            ALU_SRA: aluOut = $signed(opA) >>> shamt;
            ALU_SLT: aluOut = xword_t'($signed(opA) < $signed(opB));
            ALU_SLTU: aluOut = xword_t'(opA < opB);
            ALU_MUL: aluOut = opA * opB; // low half only
            ALU_RETB: aluOut = opB;
            default: aluOut = '0;
        endcase
        case (headWbSel)
            WB_ALU: nextResult = aluOut;
            WB_LINK: nextResult = headPc + xword_t'(4);
            WB_WORD: nextResult = {{($bits(xword_t) - 32){aluOut[31]}}, aluOut[31:0]};
            default: nextResult = '0;
        endcase
        case (headBrCond)
            BR_ALWAYS: taken = 1'b1;
            BR_EQ: taken = headRs1 == headRs2;
            BR_NE: taken = headRs1 != headRs2;
            BR_LT: taken = $signed(headRs1) < $signed(headRs2);
            BR_GE: taken = $signed(headRs1) >= $signed(headRs2);
            BR_LTU: taken = headRs1 < headRs2;
            BR_GEU: taken = headRs1 >= headRs2;
            default: taken = 1'b0;
        endcase
    end

    // one op at a time, next pop after resultValid
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            resultValid <= 1'b0;
            divStart <= 1'b0;
        end else begin
            resultValid <= divDone || (pop && !isDiv);
            divStart <= pop && isDiv;
            if (pop) busy <= 1'b1;
            else if (resultValid) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result <= nextResult;
            rdWrite <= headRdWrite;
            memRead <= headMemRead;
            memWriteMask <= headMemWriteMask;
            readNum <= headReadNum;
            loadSext <= headLoadSext;
            branchTaken <= taken;
            branchTarget <= headJumpReg ? ((headRs1 + headImm) & ~xword_t'(1))
                                        : headPc + headImm;
            illegal <= headIllegal;
            dividend <= headRs1;
            divisor <= headRs2;
            divSigned <= headAluOp inside {ALU_DIV, ALU_REM};
            divRem <= headAluOp inside {ALU_REM, ALU_REMU};
            divWord <= headWbSel == WB_WORD;
        end
        if (divDone) result <= divResult;
    end

    serialDivider uDiv (.*);

endmodule

//--- source/decodeExecTop.sv
module decodeExecTop (
    input  logic clk,
    input  logic rst,
    input  logic instValid,
    input  execPkg::inst_t inst,
    input  execPkg::xword_t imm, rs1, rs2, pc,
    output logic queueFull,
    output logic overflowErr,
    output logic resultValid,
    output execPkg::xword_t result,
    output logic rdWrite, memRead,
    output execPkg::wmask_t memWriteMask,
    output execPkg::rdnum_t readNum,
    output logic loadSext, branchTaken,
    output execPkg::xword_t branchTarget,
    output logic illegal
);
    import execPkg::*;

    // decoder to queue uses dec*, queue head to execute uses head*
    logic decValid, headValid, pop;
    aluOp_t decAluOp, headAluOp;
    selA_t decSelA, headSelA;
    selB_t decSelB, headSelB;
    wbSel_t decWbSel, headWbSel;
    brCond_t decBrCond, headBrCond;
    logic decJumpReg, decRdWrite, decMemRead, decLoadSext, decShift32, decIllegal;
    logic headJumpReg, headRdWrite, headMemRead, headLoadSext, headShift32, headIllegal;
    wmask_t decMemWriteMask, headMemWriteMask;
    rdnum_t decReadNum, headReadNum;
    xword_t decImm, decRs1, decRs2, decPc;
    xword_t headImm, headRs1, headRs2, headPc;

    instDecoder uDecoder (.*);

    opQueue uQueue (.*);

    execUnit uExec (.*);

endmodule

//--- dv/decodeExecTb.sv
`include "exec_cfg.svh"

module decodeExecTb;
    import execPkg::*;

    localparam int cyclesPerVec = 80; // watchdog budget per vector

    logic clk, rst, instValid;
    inst_t inst;
    xword_t imm, rs1, rs2, pc;
    logic queueFull, overflowErr, resultValid;
    logic rdWrite, memRead, loadSext, branchTaken, illegal;
    xword_t result, branchTarget;
    wmask_t memWriteMask;
    rdnum_t readNum;

    string vecName[$];
    inst_t vecInst[$];
    xword_t vecImm[$], vecRs1[$], vecRs2[$], vecPc[$];
    xword_t vecResult[$], vecTarget[$];
    logic [4:0] vecFlags[$]; // rdWrite, memRead, loadSext, taken, illegal
    wmask_t vecMask[$];
    rdnum_t vecNum[$];
    int pending[$]; // issued, waiting for a result
    int nVec;
    int nChecked;
    int nStrobed;
    integer seed;

    decodeExecTop uut (.*);

    always #2 clk = ~clk;

    task automatic checkValue(input string testName, input string field,
                              input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     testName, field, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic readVectors;
        int fd;
        int n;
        string line;
        string name;
        logic [63:0] vInst, vImm, vRs1, vRs2, vPc, vRes, vWr, vRd;
        logic [63:0] vMask, vNum, vSext, vTaken, vTgt, vIll;
        fd = $fopen("dv/exec_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file dv/exec_vectors.txt");
            $display("Testbench failed");
            $fatal(1, "no vector file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue; // blank or column notes
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, vInst, vImm, vRs1, vRs2, vPc, vRes, vWr, vRd,
                        vMask, vNum, vSext, vTaken, vTgt, vIll);
            if (n != 15) begin
                $display("A line of the vector file has %0d fields instead of 15", n);
                $display("Testbench failed");
                $fatal(1, "bad vector line");
            end
            vecName.push_back(name);
            vecInst.push_back(vInst[31:0]);
            vecImm.push_back(vImm);
            vecRs1.push_back(vRs1);
            vecRs2.push_back(vRs2);
            vecPc.push_back(vPc);
            vecResult.push_back(vRes);
            vecTarget.push_back(vTgt);
            vecFlags.push_back({vWr[0], vRd[0], vSext[0], vTaken[0], vIll[0]});
            vecMask.push_back(vMask[7:0]);
            vecNum.push_back(vNum[3:0]);
        end
        $fclose(fd);
        if (vecName.size() == 0) begin
            $display("The vector file holds no vectors");
            $display("Testbench failed");
            $fatal(1, "empty vector file");
        end
        nVec = vecName.size();
    endtask

    task automatic driveVectors;
        int gap;
        for (int i = 0; i < nVec; i++) begin
            gap = int'($unsigned($random(seed)) % 3); // 0 gives back-to-back strobes
            repeat (gap) @(negedge clk);
            while (queueFull) @(negedge clk);
            inst = vecInst[i];
            imm = vecImm[i];
            rs1 = vecRs1[i];
            rs2 = vecRs2[i];
            pc = vecPc[i];
            instValid = 1'b1;
            pending.push_back(i);
            @(negedge clk);
            instValid = 1'b0;
        end
    endtask

    // strobes taken by the decoder so far
    always @(posedge clk) begin
        if (!rst && instValid) nStrobed++;
    end

    // outputs are registered, so they are stable at the falling edge
    always @(negedge clk) begin : checkResults
        int idx;
        int inFlight;
        if (!rst) begin
            checkValue("queue", "overflowErr", 64'(1'b0), 64'(overflowErr));
            if (resultValid) begin
                if (pending.size() == 0) begin
                    $display("A result came out with no instruction pending");
                    $display("Testbench failed");
                    $fatal(1, "unexpected result");
                end else begin
                    idx = pending.pop_front();
                    checkValue(vecName[idx], "result", vecResult[idx], result);
                    checkValue(vecName[idx], "rdWrite", 64'(vecFlags[idx][4]), 64'(rdWrite));
                    checkValue(vecName[idx], "memRead", 64'(vecFlags[idx][3]), 64'(memRead));
                    checkValue(vecName[idx], "memWriteMask", 64'(vecMask[idx]),
                               64'(memWriteMask));
                    checkValue(vecName[idx], "readNum", 64'(vecNum[idx]), 64'(readNum));
                    checkValue(vecName[idx], "loadSext", 64'(vecFlags[idx][2]), 64'(loadSext));
                    checkValue(vecName[idx], "branchTaken", 64'(vecFlags[idx][1]),
                               64'(branchTaken));
                    checkValue(vecName[idx], "branchTarget", vecTarget[idx], branchTarget);
                    checkValue(vecName[idx], "illegal", 64'(vecFlags[idx][0]), 64'(illegal));
                    nChecked++;
                end
            end
            // decode slot and queue, plus at most one op in execute
            inFlight = nStrobed - nChecked;
            if (resultValid || inFlight != `EXEC_QDEPTH) begin // nothing in execute on a result
                checkValue("queue", "queueFull", 64'(inFlight >= `EXEC_QDEPTH), 64'(queueFull));
            end
        end
    end

    initial begin : watchdog
        wait (nVec > 0);
        repeat (nVec * cyclesPerVec) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d results checked",
                 nVec * cyclesPerVec, nChecked, nVec);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instValid = 1'b0;
        inst = '0;
        imm = '0;
        rs1 = '0;
        rs2 = '0;
        pc = '0;
        nVec = 0;
        nChecked = 0;
        nStrobed = 0;
        seed = 32'h289755e0;
        readVectors();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        driveVectors();
        wait (nChecked == nVec);
        repeat (20) @(posedge clk); // stray results would show up here
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- dv/exec_vectors.txt
# name inst imm rs1 rs2 pc, then expected result rdWrite memRead memWriteMask readNum loadSext
# branchTaken branchTarget illegal; all numbers are hex
add       003100B3 0 7FFFFFFFFFFFFFFF 1 1000 8000000000000000 1 0 00 0 0 0 1000 0
sub       403100B3 0 5 7 1000 FFFFFFFFFFFFFFFE 1 0 00 0 0 0 1000 0
div       023140B3 0 FFFFFFFFFFFFFFF9 2 1000 FFFFFFFFFFFFFFFD 1 0 00 0 0 0 1000 0
xor       003140B3 0 F0F0 FF00 1000 0FF0 1 0 00 0 0 0 1000 0
and       003170B3 0 F0F0 FF00 1000 F000 1 0 00 0 0 0 1000 0
sll       003110B3 0 1 44 1000 10 1 0 00 0 0 0 1000 0
sra       403150B3 0 8000000000000000 4 1000 F800000000000000 1 0 00 0 0 0 1000 0
slt       003120B3 0 FFFFFFFFFFFFFFFF 1 1000 1 1 0 00 0 0 0 1000 0
sltu      003130B3 0 FFFFFFFFFFFFFFFF 1 1000 0 1 0 00 0 0 0 1000 0
mul       023100B3 0 100000001 100000003 1000 400000003 1 0 00 0 0 0 1000 0
rem       023160B3 0 FFFFFFFFFFFFFFF9 2 1000 FFFFFFFFFFFFFFFF 1 0 00 0 0 0 1000 0
addw      003100BB 0 7FFFFFFF 1 1000 FFFFFFFF80000000 1 0 00 0 0 0 1000 0
sraw      403150BB 0 80000000 4 1000 FFFFFFFFF8000000 1 0 00 0 0 0 1000 0
srliw     0041509B 4 FFFFFFFF80000000 0 1000 8000000 1 0 00 0 0 0 1004 0
addi      FFF10093 FFFFFFFFFFFFFFFF 10 0 1000 F 1 0 00 0 0 0 FFF 0
divu_zero 023150B3 0 1234 0 1000 FFFFFFFFFFFFFFFF 1 0 00 0 0 0 1000 0
lui       123450B7 12345000 0 0 1000 12345000 1 0 00 0 0 0 12346000 0
auipc     00001097 1000 0 0 1000 2000 1 0 00 0 0 0 2000 0
ld        00813083 8 2000 0 1000 2008 1 1 00 8 1 0 1008 0
lbu       01014083 10 2000 0 1000 2010 1 1 00 1 0 0 1010 0
remu_zero 023170B3 0 1234 0 1000 1234 1 0 00 0 0 0 1000 0
sh        FE311F23 FFFFFFFFFFFFFFFE 2000 0 1000 1FFE 0 0 03 0 0 0 FFE 0
sd        00313C23 18 2000 0 1000 2018 0 0 FF 0 0 0 1018 0
beq       02310063 20 5 5 1000 0 0 0 00 0 0 1 1020 0
div_ovf   023140B3 0 8000000000000000 FFFFFFFFFFFFFFFF 1000 8000000000000000 1 0 00 0 0 0 1000 0
bne       02311063 20 5 5 1000 0 0 0 00 0 0 0 1020 0
blt       02314063 20 FFFFFFFFFFFFFFFF 1 1000 0 0 0 00 0 0 1 1020 0
divw      023140BB 0 FFFFFFF9 2 1000 FFFFFFFFFFFFFFFD 1 0 00 0 0 0 1000 0
jal       100000EF 100 0 0 1000 1004 1 0 00 0 0 1 1100 0
jalr      005100E7 5 3000 0 1000 1004 1 0 00 0 0 1 3004 0
bad_op    FFFFFFFF 0 0 0 1000 0 0 0 00 0 0 0 1000 1
remuw     023170BB 0 FFFFFFFF00000007 500000003 1000 1 1 0 00 0 0 0 1000 0
bad_mulh  023110B3 0 3 4 1000 0 0 0 00 0 0 0 1000 1

//--- list.f
+incdir+source
source/execPkg.sv
source/instDecoder.sv
source/opQueue.sv
source/serialDivider.sv
source/execUnit.sv
source/decodeExecTop.sv
dv/decodeExecTb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f list.f --top-module decodeExecTb -o decodeExecSim &&
    ./obj_dir/decodeExecSim > sim.log 2>&1 ||
    echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
if grep -q "Testbench failed" sim.log 2>/dev/null || ! grep -q "Testbench passed" sim.log 2>/dev/null; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
